// ==== hw/cong_pkg.sv ====
/* Shared widths, constants and types for the congestion manager admission stage:
   descriptor length, occupancy, per-queue tail state and the admission FSM states */

package cong_pkg;

    ////////////////////////////////////////////////////////////
    // Queue memory geometry

    // Bytes per queue memory word
    localparam int WORD_BYTES = 64;
    localparam int WORDS_PER_PAGE = 64;

    localparam int TAIL_W = $clog2(WORDS_PER_PAGE);
    // Page number width, enough for up to 32 pages
    localparam int PAGE_W = 5;

    ////////////////////////////////////////////////////////////
    // Descriptor fields and rules

    localparam int PRIO_W = 3;

    // Lowest priority that maps to class 1
    localparam int PRIO_CLASS_SPLIT = 5;
    // Policer mark ignored at and above this priority
    localparam int POLICER_PRIO_LIMIT = 6;

    // Packet byte length, 64 to 1500
    typedef logic [10:0] len_t;

    // Queue byte occupancy, also the drop threshold
    typedef logic [19:0] occ_t;

    typedef struct packed {
        logic [TAIL_W-1:0] tail_word;
        logic [PAGE_W-1:0] page;
        logic              page_valid;
    } tail_state_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_DECIDE,
        ST_RESULT
    } admit_state_e;

endpackage

// ==== hw/queue_table.sv ====
/* Per-queue state table with a registered read port and a single write port */

`timescale 1ns/100ps

module queue_table #(
    parameter type    entry_t     = logic [7:0],
    parameter int     DEPTH       = 8,
    parameter entry_t RESET_VALUE = '0,
    localparam int    IDX_W       = $clog2(DEPTH)
) (
    input  logic             core_clk_ifc,
    input  logic             rst_n,

    input  logic [IDX_W-1:0] rd_idx,
    output entry_t           rd_data,

    input  logic             we,
    input  logic [IDX_W-1:0] wr_idx,
    input  entry_t           wr_data
);

    entry_t entries [DEPTH];

    // Read data follows the index by one cycle and sees the
    // old entry when the same queue is written in that cycle
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= RESET_VALUE;
        end else begin
            rd_data <= entries[rd_idx];
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= RESET_VALUE;
            end
        end else if (we) begin
            entries[wr_idx] <= wr_data;
        end
    end

endmodule

// ==== hw/page_alloc_counter.sv ====
/* Free-page counter with a rotating next-page number */

`timescale 1ns/100ps

module page_alloc_counter import cong_pkg::*; #(
    parameter int  NUM_PAGES = 32,
    localparam int FREE_W    = $clog2(NUM_PAGES + 1)
) (
    input  logic              core_clk_ifc,
    input  logic              rst_n,

    input  logic              alloc,
    input  logic              page_release,

    output logic [FREE_W-1:0] free_pages,
    output logic [PAGE_W-1:0] next_page
);

    ////////////////////////////////////////////////////////////
    // Free page count

    // Alloc and release together cancel out
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            free_pages <= FREE_W'(NUM_PAGES);
        end else if (alloc && !page_release) begin
            free_pages <= free_pages - 1'b1;
        end else if (page_release && !alloc) begin
            // saturate, a stray release never goes past the pool size
            if (free_pages != FREE_W'(NUM_PAGES)) begin
                free_pages <= free_pages + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Next page number

    // Pages are handed out in rotation
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            next_page <= '0;
        end else if (alloc) begin
            if (next_page == PAGE_W'(NUM_PAGES - 1)) begin
                next_page <= '0;
            end else begin
                next_page <= next_page + 1'b1;
            end
        end
    end

endmodule

// ==== hw/admit_fsm.sv ====
/* Admission FSM: queue lookup, drop decision, result handshake and commit of
   queue occupancy, tail state and threshold writes */

`timescale 1ns/100ps

module admit_fsm import cong_pkg::*; #(
    parameter int  NUM_EGR_PORTS = 4,
    parameter int  NUM_PAGES     = 32,
    localparam int PORT_W        = $clog2(NUM_EGR_PORTS),
    localparam int QUEUE_W       = $clog2(2 * NUM_EGR_PORTS),
    localparam int FREE_W        = $clog2(NUM_PAGES + 1)
) (
    input  logic               core_clk_ifc,
    input  logic               rst_n,

    // Descriptor input
    input  logic               desc_valid,
    output logic               desc_ready,
    input  logic [PORT_W-1:0]  desc_port,
    input  logic [PRIO_W-1:0]  desc_prio,
    input  len_t               desc_len,
    input  logic               desc_mark,

    // Threshold configuration
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  logic [QUEUE_W-1:0] cfg_queue,
    input  occ_t               cfg_thresh,

    // Admission result
    output logic               res_valid,
    input  logic               res_ready,
    output logic [QUEUE_W-1:0] res_queue,
    output logic               res_accept,
    output logic               res_malloc,
    output logic [PAGE_W-1:0]  res_page,
    output logic [TAIL_W-1:0]  res_tail,

    // Queue tables
    output logic [QUEUE_W-1:0] tbl_rd_idx,
    input  occ_t               thresh_rd,
    input  occ_t               occ_rd,
    input  tail_state_t        tail_rd,
    output logic               thresh_we,
    output logic               occ_we,
    output logic               tail_we,
    output logic [QUEUE_W-1:0] tbl_wr_idx,
    output occ_t               occ_wr,
    output tail_state_t        tail_wr,
    output occ_t               thresh_wr,

    // Page counter
    output logic               alloc,
    input  logic [FREE_W-1:0]  free_pages,
    input  logic [PAGE_W-1:0]  next_page
);

    // Word count of one packet, up to 1 + max length / word size
    localparam int WCNT_W = $bits(len_t) + 1 - $clog2(WORD_BYTES);
    localparam int OCC_W  = $bits(occ_t);

    admit_state_e state;
    admit_state_e state_nxt;

    // Latched descriptor
    logic [QUEUE_W-1:0] q_idx;
    len_t               d_len;
    logic [PRIO_W-1:0]  d_prio;
    logic               d_mark;

    logic [WCNT_W-1:0]  words;
    logic [TAIL_W:0]    tail_sum;
    logic [OCC_W:0]     occ_sum;
    logic               need_page;
    logic               over_thresh;
    logic               policed;
    logic               accept;
    logic               res_fire;
    occ_t               occ_new;
    tail_state_t        tail_new;

    ////////////////////////////////////////////////////////////
    // Handshakes and state

    // Configuration wins over a descriptor in the same cycle
    assign cfg_ready  = (state == ST_IDLE);
    assign desc_ready = (state == ST_IDLE) && !cfg_valid;
    assign res_valid  = (state == ST_RESULT);
    assign res_fire   = res_valid && res_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (desc_valid && desc_ready) state_nxt = ST_LOOKUP;
            ST_LOOKUP: state_nxt = ST_DECIDE;
            ST_DECIDE: state_nxt = ST_RESULT;
            ST_RESULT: if (res_ready) state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Queue index is {egress port, class}
    always_ff @(posedge core_clk_ifc) begin
        if (desc_valid && desc_ready) begin
            q_idx  <= {desc_port, desc_prio >= PRIO_W'(PRIO_CLASS_SPLIT)};
            d_len  <= desc_len;
            d_prio <= desc_prio;
            d_mark <= desc_mark;
        end
    end

    ////////////////////////////////////////////////////////////
    // Drop decision

    assign words     = WCNT_W'(({1'b0, d_len} + 12'(WORD_BYTES - 1)) >> $clog2(WORD_BYTES));
    assign tail_sum  = {1'b0, tail_rd.tail_word} + (TAIL_W + 1)'(words);
    assign need_page = !tail_rd.page_valid || (tail_sum >= (TAIL_W + 1)'(WORDS_PER_PAGE));

    assign occ_sum     = {1'b0, occ_rd} + (OCC_W + 1)'(d_len);
    assign over_thresh = occ_sum > {1'b0, thresh_rd};
    assign policed     = d_mark && (d_prio < PRIO_W'(POLICER_PRIO_LIMIT));

    // Rules in order: threshold, policer, page exhaustion
    assign accept = !over_thresh && !policed && !(need_page && (free_pages == '0));

    // Tail wraps within the page since WORDS_PER_PAGE is a power of two
    always_ff @(posedge core_clk_ifc) begin
        if (state == ST_DECIDE) begin
            res_accept <= accept;
            res_malloc <= accept && need_page;
            occ_new    <= occ_sum[OCC_W-1:0];
            if (accept) begin
                tail_new.tail_word  <= tail_sum[TAIL_W-1:0];
                tail_new.page       <= need_page ? next_page : tail_rd.page;
                tail_new.page_valid <= 1'b1;
            end else begin
                tail_new <= tail_rd;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Result and commit

    assign res_queue = q_idx;
    assign res_page  = tail_new.page;
    assign res_tail  = tail_new.tail_word;

    assign tbl_rd_idx = q_idx;
    assign tbl_wr_idx = (state == ST_RESULT) ? q_idx : cfg_queue;

    assign thresh_we = cfg_valid && cfg_ready;
    assign thresh_wr = cfg_thresh;

    // Tables and counter commit only on the result transfer
    assign occ_we  = res_fire && res_accept;
    assign tail_we = res_fire && res_accept;
    assign alloc   = res_fire && res_malloc;
    assign occ_wr  = occ_new;
    assign tail_wr = tail_new;

endmodule

// ==== hw/congestion_manager.sv ====
/* Congestion manager admission stage top: threshold, occupancy and tail tables,
   page counter and admission FSM */

`timescale 1ns/100ps

module congestion_manager import cong_pkg::*; #(
    parameter int  NUM_EGR_PORTS  = 4,
    parameter int  NUM_PAGES      = 32,
    parameter int  DEFAULT_THRESH = 16384,
    localparam int NUM_QUEUES     = 2 * NUM_EGR_PORTS,
    localparam int PORT_W         = $clog2(NUM_EGR_PORTS),
    localparam int QUEUE_W        = $clog2(NUM_QUEUES),
    localparam int FREE_W         = $clog2(NUM_PAGES + 1)
) (
    input  logic               core_clk_ifc,
    input  logic               rst_n,

    input  logic               desc_valid,
    output logic               desc_ready,
    input  logic [PORT_W-1:0]  desc_port,
    input  logic [PRIO_W-1:0]  desc_prio,
    input  len_t               desc_len,
    input  logic               desc_mark,

    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  logic [QUEUE_W-1:0] cfg_queue,
    input  occ_t               cfg_thresh,

    output logic               res_valid,
    input  logic               res_ready,
    output logic [QUEUE_W-1:0] res_queue,
    output logic               res_accept,
    output logic               res_malloc,
    output logic [PAGE_W-1:0]  res_page,
    output logic [TAIL_W-1:0]  res_tail,

    input  logic               page_release,
    output logic [FREE_W-1:0]  free_pages
);

    logic [QUEUE_W-1:0] tbl_rd_idx;
    logic [QUEUE_W-1:0] tbl_wr_idx;
    occ_t               thresh_rd;
    occ_t               occ_rd;
    tail_state_t        tail_rd;
    logic               thresh_we;
    logic               occ_we;
    logic               tail_we;
    occ_t               thresh_wr;
    occ_t               occ_wr;
    tail_state_t        tail_wr;
    logic               alloc;
    logic [PAGE_W-1:0]  next_page;

    ////////////////////////////////////////////////////////////
    // Admission control

    admit_fsm #(
        .NUM_EGR_PORTS (NUM_EGR_PORTS),
        .NUM_PAGES     (NUM_PAGES)
    ) admit_fsm_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .desc_port    (desc_port),
        .desc_prio    (desc_prio),
        .desc_len     (desc_len),
        .desc_mark    (desc_mark),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .cfg_queue    (cfg_queue),
        .cfg_thresh   (cfg_thresh),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res_queue    (res_queue),
        .res_accept   (res_accept),
        .res_malloc   (res_malloc),
        .res_page     (res_page),
        .res_tail     (res_tail),
        .tbl_rd_idx   (tbl_rd_idx),
        .thresh_rd    (thresh_rd),
        .occ_rd       (occ_rd),
        .tail_rd      (tail_rd),
        .thresh_we    (thresh_we),
        .occ_we       (occ_we),
        .tail_we      (tail_we),
        .tbl_wr_idx   (tbl_wr_idx),
        .occ_wr       (occ_wr),
        .tail_wr      (tail_wr),
        .thresh_wr    (thresh_wr),
        .alloc        (alloc),
        .free_pages   (free_pages),
        .next_page    (next_page)
    );

    page_alloc_counter #(
        .NUM_PAGES (NUM_PAGES)
    ) page_alloc_counter_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .page_release (page_release),
        .free_pages   (free_pages),
        .next_page    (next_page)
    );

    ////////////////////////////////////////////////////////////
    // Per-queue state tables

    queue_table #(
        .entry_t     (occ_t),
        .DEPTH       (NUM_QUEUES),
        .RESET_VALUE (occ_t'(DEFAULT_THRESH))
    ) thresh_table_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .rd_idx       (tbl_rd_idx),
        .rd_data      (thresh_rd),
        .we           (thresh_we),
        .wr_idx       (tbl_wr_idx),
        .wr_data      (thresh_wr)
    );

    queue_table #(
        .entry_t     (occ_t),
        .DEPTH       (NUM_QUEUES),
        .RESET_VALUE ('0)
    ) occ_table_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .rd_idx       (tbl_rd_idx),
        .rd_data      (occ_rd),
        .we           (occ_we),
        .wr_idx       (tbl_wr_idx),
        .wr_data      (occ_wr)
    );

    // Cleared tail state has no valid page
    queue_table #(
        .entry_t     (tail_state_t),
        .DEPTH       (NUM_QUEUES),
        .RESET_VALUE ('0)
    ) tail_table_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .rd_idx       (tbl_rd_idx),
        .rd_data      (tail_rd),
        .we           (tail_we),
        .wr_idx       (tbl_wr_idx),
        .wr_data      (tail_wr)
    );

endmodule

// ==== sim/cong_model.svh ====
/* Reference model of the queue tables, the page counter and the admission rules */

`ifndef CONG_MODEL_SVH
`define CONG_MODEL_SVH

// Per-queue state
int unsigned q_thresh     [NUM_QUEUES];
int unsigned q_occ        [NUM_QUEUES];
int unsigned q_tail       [NUM_QUEUES];
int unsigned q_page       [NUM_QUEUES];
bit          q_page_valid [NUM_QUEUES];
int unsigned pages_free;
int unsigned page_next;

// Prediction for the descriptor in flight
int unsigned exp_queue;
int unsigned exp_len;
int unsigned exp_page;
int unsigned exp_tail;
bit          exp_accept;
bit          exp_malloc;

function automatic void clear_model();
    for (int i = 0; i < NUM_QUEUES; i++) begin
        q_thresh[i]     = DEFAULT_THRESH;
        q_occ[i]        = 0;
        q_tail[i]       = 0;
        q_page[i]       = 0;
        q_page_valid[i] = 1'b0;
    end
    pages_free = NUM_PAGES;
    page_next  = 0;
endfunction

function automatic void set_model_thresh(input int unsigned q, input int unsigned t);
    q_thresh[q] = t;
endfunction

// Release saturates at the pool size
function automatic void release_model_page();
    if (pages_free < NUM_PAGES) begin
        pages_free++;
    end
endfunction

function automatic void predict_admission(input int port, input int prio, input int len,
                                          input bit mark);
    int unsigned q;
    int unsigned words;
    bit          need;
    bit          acc;
    q     = 2 * port + ((prio >= PRIO_CLASS_SPLIT) ? 1 : 0);
    words = len / WORD_BYTES + (((len % WORD_BYTES) != 0) ? 1 : 0);
    need  = !q_page_valid[q] || (q_tail[q] + words >= WORDS_PER_PAGE);
    if (q_occ[q] + len > q_thresh[q]) begin
        acc = 1'b0;
    end else if (mark && prio < POLICER_PRIO_LIMIT) begin
        acc = 1'b0;
    end else if (need && pages_free == 0) begin
        acc = 1'b0;
    end else begin
        acc = 1'b1;
    end
    exp_queue  = q;
    exp_len    = len;
    exp_accept = acc;
    exp_malloc = acc && need;
    // A drop reports the queue's unchanged tail state
    if (acc) begin
        exp_tail = (q_tail[q] + words) % WORDS_PER_PAGE;
        exp_page = need ? page_next : q_page[q];
    end else begin
        exp_tail = q_tail[q];
        exp_page = q_page[q];
    end
endfunction

function automatic void commit_admission();
    if (exp_accept) begin
        q_occ[exp_queue]        = q_occ[exp_queue] + exp_len;
        q_tail[exp_queue]       = exp_tail;
        q_page[exp_queue]       = exp_page;
        q_page_valid[exp_queue] = 1'b1;
        if (exp_malloc) begin
            pages_free--;
            page_next = (page_next + 1) % NUM_PAGES;
        end
    end
endfunction

`endif

// ==== sim/cong_tb.sv ====
/* Testbench for the congestion manager: clock, reset, DUT, random and directed
   descriptor sequences checked against a reference model */

`timescale 1ns/100ps

module cong_tb import cong_pkg::*;;

    localparam int NUM_EGR_PORTS  = 4;
    localparam int NUM_PAGES      = 32;
    localparam int DEFAULT_THRESH = 16384;
    localparam int NUM_QUEUES     = 2 * NUM_EGR_PORTS;
    localparam int PORT_W         = $clog2(NUM_EGR_PORTS);
    localparam int QUEUE_W        = $clog2(NUM_QUEUES);
    localparam int FREE_W         = $clog2(NUM_PAGES + 1);
    localparam int WAIT_LIMIT     = 200;

    logic               core_clk_ifc;
    logic               rst_n;
    logic               desc_valid;
    logic               desc_ready;
    logic [PORT_W-1:0]  desc_port;
    logic [PRIO_W-1:0]  desc_prio;
    len_t               desc_len;
    logic               desc_mark;
    logic               cfg_valid;
    logic               cfg_ready;
    logic [QUEUE_W-1:0] cfg_queue;
    occ_t               cfg_thresh;
    logic               res_valid;
    logic               res_ready;
    logic [QUEUE_W-1:0] res_queue;
    logic               res_accept;
    logic               res_malloc;
    logic [PAGE_W-1:0]  res_page;
    logic [TAIL_W-1:0]  res_tail;
    logic               page_release;
    logic [FREE_W-1:0]  free_pages;

    // Last result seen on the output
    logic [31:0] got_queue;
    logic [31:0] got_accept;
    logic [31:0] got_malloc;
    logic [31:0] got_page;
    logic [31:0] got_tail;

    `include "cong_model.svh"

    congestion_manager #(
        .NUM_EGR_PORTS  (NUM_EGR_PORTS),
        .NUM_PAGES      (NUM_PAGES),
        .DEFAULT_THRESH (DEFAULT_THRESH)
    ) dut_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .desc_port    (desc_port),
        .desc_prio    (desc_prio),
        .desc_len     (desc_len),
        .desc_mark    (desc_mark),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .cfg_queue    (cfg_queue),
        .cfg_thresh   (cfg_thresh),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res_queue    (res_queue),
        .res_accept   (res_accept),
        .res_malloc   (res_malloc),
        .res_page     (res_page),
        .res_tail     (res_tail),
        .page_release (page_release),
        .free_pages   (free_pages)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                               $time, what, got, expected));
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge core_clk_ifc);
        #2;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(posedge core_clk_ifc);
        #2;
        rst_n = 1'b1;
        clear_model();
    endtask

    task automatic write_thresh(input int q, input int unsigned t);
        int  waited;
        bit  taken;
        cfg_queue  = QUEUE_W'(q);
        cfg_thresh = occ_t'(t);
        cfg_valid  = 1'b1;
        waited     = 0;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge core_clk_ifc);
            taken = cfg_ready;
            next_cycle();
            waited++;
            if (!taken && waited > WAIT_LIMIT) fail_run("Timeout waiting for cfg_ready");
        end
        cfg_valid = 1'b0;
        set_model_thresh(q, t);
    endtask

    task automatic release_page();
        page_release = 1'b1;
        next_cycle();
        page_release = 1'b0;
        release_model_page();
        @(negedge core_clk_ifc);
        check_value("free_pages after release", free_pages, pages_free);
        next_cycle();
    endtask

    task automatic send_desc(input int port, input int prio, input int len, input bit mark);
        int waited;
        bit taken;
        desc_port  = PORT_W'(port);
        desc_prio  = PRIO_W'(prio);
        desc_len   = len_t'(len);
        desc_mark  = mark;
        desc_valid = 1'b1;
        waited     = 0;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge core_clk_ifc);
            taken = desc_ready;
            next_cycle();
            waited++;
            if (!taken && waited > WAIT_LIMIT) fail_run("Timeout waiting for desc_ready");
        end
        desc_valid = 1'b0;
    endtask

    // Waits for the result transfer and checks latency and held data
    task automatic collect_result(input bit backpressure);
        int cycles;
        bit seen;
        bit done;
        cycles = 0;
        seen   = 1'b0;
        done   = 1'b0;
        while (!done) begin
            if (backpressure) res_ready = ($urandom_range(3) == 0);
            @(negedge core_clk_ifc);
            cycles++;
            if (res_valid) begin
                if (!seen) begin
                    check_value("result latency", cycles, 3);
                    got_queue  = res_queue;
                    got_accept = res_accept;
                    got_malloc = res_malloc;
                    got_page   = res_page;
                    got_tail   = res_tail;
                    seen       = 1'b1;
                end else begin
                    check_value("held res_queue", res_queue, got_queue);
                    check_value("held res_accept", res_accept, got_accept);
                    check_value("held res_malloc", res_malloc, got_malloc);
                    check_value("held res_page", res_page, got_page);
                    check_value("held res_tail", res_tail, got_tail);
                end
                check_value("desc_ready while result pending", desc_ready, 0);
                done = res_ready;
            end
            next_cycle();
            if (!done && cycles > WAIT_LIMIT) fail_run("Timeout waiting for a result transfer");
        end
        res_ready = 1'b1;
    endtask

    task automatic run_desc(input int port, input int prio, input int len, input bit mark,
                            input bit backpressure);
        predict_admission(port, prio, len, mark);
        send_desc(port, prio, len, mark);
        collect_result(backpressure);
        check_value("res_queue", got_queue, exp_queue);
        check_value("res_accept", got_accept, exp_accept);
        check_value("res_malloc", got_malloc, exp_malloc);
        check_value("res_page", got_page, exp_page);
        check_value("res_tail", got_tail, exp_tail);
        commit_admission();
        // One result per descriptor and no repeat
        @(negedge core_clk_ifc);
        check_value("res_valid after transfer", res_valid, 0);
        check_value("free_pages", free_pages, pages_free);
        next_cycle();
    endtask

    task automatic random_desc(input bit backpressure);
        run_desc($urandom_range(NUM_EGR_PORTS - 1), $urandom_range(7),
                 $urandom_range(1500, 64), ($urandom_range(9) == 0), backpressure);
    endtask

    function automatic int prio_for_queue(input int q);
        return (q % 2) ? $urandom_range(7, PRIO_CLASS_SPLIT)
                       : $urandom_range(PRIO_CLASS_SPLIT - 1);
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          q;
        int          len;
        int          fills;
        void'($urandom(35));
        rst_n        = 1'b0;
        desc_valid   = 1'b0;
        desc_port    = '0;
        desc_prio    = '0;
        desc_len     = '0;
        desc_mark    = 1'b0;
        cfg_valid    = 1'b0;
        cfg_queue    = '0;
        cfg_thresh   = '0;
        res_ready    = 1'b1;
        page_release = 1'b0;

        // State right after reset
        apply_reset();
        @(negedge core_clk_ifc);
        check_value("res_valid after reset", res_valid, 0);
        check_value("free_pages after reset", free_pages, NUM_PAGES);
        check_value("desc_ready after reset", desc_ready, 1);
        check_value("cfg_ready after reset", cfg_ready, 1);
        next_cycle();
        release_page();

        // Random traffic
        for (int i = 0; i < 300; i++) random_desc(1'b0);

        // Threshold boundary at the limit and one byte over
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            q = $urandom_range(NUM_QUEUES - 1);
            run_desc(q / 2, prio_for_queue(q), $urandom_range(1500, 64), 1'b0, 1'b0);
            len = $urandom_range(1500, 64);
            write_thresh(q, q_occ[q] + len);
            run_desc(q / 2, prio_for_queue(q), len, 1'b0, 1'b0);
            check_value("accept at threshold", got_accept, 1);
            len = $urandom_range(1500, 64);
            write_thresh(q, q_occ[q] + len - 1);
            run_desc(q / 2, prio_for_queue(q), len, 1'b0, 1'b0);
            check_value("accept one byte over threshold", got_accept, 0);
        end

        // Policer mark by priority
        apply_reset();
        for (int p = 0; p < 8; p++) begin
            run_desc($urandom_range(NUM_EGR_PORTS - 1), p, $urandom_range(1500, 64),
                     1'b1, 1'b0);
            check_value("accept of marked descriptor", got_accept, (p >= POLICER_PRIO_LIMIT));
        end

        // Page exhaustion on queue 0 and a fresh queue that needs a page
        apply_reset();
        for (int i = 0; i < NUM_QUEUES; i++) write_thresh(i, 20'hFFFFF);
        fills = 0;
        while (free_pages != 0) begin
            run_desc(0, 0, 1500, 1'b0, 1'b0);
            fills++;
            if (fills > 4 * NUM_PAGES) fail_run("free_pages never reached zero");
        end
        run_desc(0, 7, 64, 1'b0, 1'b0);
        check_value("accept with no free page", got_accept, 0);
        release_page();
        run_desc(0, 7, 64, 1'b0, 1'b0);
        check_value("accept after page release", got_accept, 1);
        check_value("malloc after page release", got_malloc, 1);

        // Random traffic under result back-pressure
        apply_reset();
        for (int i = 0; i < 100; i++) random_desc(1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+sim
hw/cong_pkg.sv
hw/queue_table.sv
hw/page_alloc_counter.sv
hw/admit_fsm.sv
hw/congestion_manager.sv
sim/cong_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the congestion manager testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module cong_tb \
    --Mdir obj_dir \
    -o cong_sim

# The simulator exit status is not trusted alone, the log decides
./obj_dir/cong_sim 2>&1 | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
